// File: logic/dram_pkg.sv
package dram_pkg;

    // burst address layout is {row, bank, col}
    localparam int ROW_W  = 14;
    localparam int BANK_W = 3;
    localparam int COL_W  = 7;      // 10-bit column, 8 beats per burst
    localparam int ADDR_W = ROW_W + BANK_W + COL_W;

    localparam int DATA_W  = 128;   // one burst of sample data
    localparam int COUNT_W = 16;    // display counters

    // in-flight limit at the request port
    localparam int MEM_OUTSTANDING = 4;
    localparam int MEM_PTR_W       = $clog2(MEM_OUTSTANDING);
    localparam int MEM_CNT_W       = $clog2(MEM_OUTSTANDING + 1);

    typedef logic [ADDR_W-1:0]    mem_addr_t;
    typedef logic [DATA_W-1:0]    mem_data_t;
    typedef logic [COUNT_W-1:0]   event_count_t;
    typedef logic [MEM_PTR_W-1:0] mem_ptr_t;
    typedef logic [MEM_CNT_W-1:0] mem_count_t;

endpackage

// File: logic/stream_pkg.sv
package stream_pkg;

    // response buffer between memory port and read-data stream
    localparam int RESP_DEPTH  = 4;
    localparam int RESP_PTR_W  = $clog2(RESP_DEPTH);
    localparam int RESP_SLOT_W = $clog2(RESP_DEPTH + 1);

    typedef logic [RESP_PTR_W-1:0]  resp_ptr_t;
    typedef logic [RESP_SLOT_W-1:0] resp_slots_t;   // 0 .. RESP_DEPTH

    // traffic generator phases, never goes back to LOAD
    typedef enum logic {
        LOAD,
        SERVE
    } tg_phase_t;

endpackage

// File: logic/dram_link_ifs.sv
// request path, traffic generator to memory port
interface mem_req_if;
    logic                valid;
    logic                we;
    dram_pkg::mem_addr_t addr;
    dram_pkg::mem_data_t wdata;
    logic                rd_tag_last;   // last flag to tag the read response
    logic                accept;
    logic                writes_idle;   // no write in flight

    modport source (output valid, we, addr, wdata, rd_tag_last, input accept, writes_idle);
    modport sink (input valid, we, addr, wdata, rd_tag_last, output accept, writes_idle);
endinterface

// read completions into the response buffer, credit based
interface read_resp_if;
    logic                    valid;   // one pulse per read completion
    dram_pkg::mem_addr_t     addr;
    logic                    last;
    dram_pkg::mem_data_t     data;
    stream_pkg::resp_slots_t free_slots;

    modport source (output valid, addr, last, data, input free_slots);
    modport sink (input valid, addr, last, data, output free_slots);
endinterface

// File: logic/traffic_generator.sv
module traffic_generator (
    input  logic                i_clk_dram_ctrl,
    input  logic                i_rst,
    input  dram_pkg::mem_data_t i_wr_data,
    input  logic                i_wr_last,
    input  logic                i_wr_valid,
    output logic                o_wr_ready,
    input  dram_pkg::mem_addr_t i_rd_addr,
    input  logic                i_rd_last,
    input  logic                i_rd_valid,
    output logic                o_rd_addr_ready,
    output logic                o_load_complete,
    mem_req_if.source           mem_req
);

    stream_pkg::tg_phase_t phase;
    dram_pkg::mem_addr_t   wr_addr;      // next burst address for the load
    logic                  wr_open;      // write stream being taken
    logic                  last_seen;    // final chunk accepted
    logic                  wr_take;

    // one stream at a time goes through to the port
    always_comb begin
        mem_req.valid   = 1'b0;
        mem_req.we      = 1'b1;
        mem_req.addr    = wr_addr;
        o_wr_ready      = 1'b0;
        o_rd_addr_ready = 1'b0;
        if (phase == stream_pkg::SERVE) begin
            mem_req.valid   = i_rd_valid;
            mem_req.we      = 1'b0;
            mem_req.addr    = i_rd_addr;
            o_rd_addr_ready = mem_req.accept;
        end else if (wr_open) begin
            mem_req.valid = i_wr_valid;
            o_wr_ready    = mem_req.accept;
        end
    end

    assign mem_req.wdata       = i_wr_data;
    assign mem_req.rd_tag_last = i_rd_last;

    assign wr_take         = (phase == stream_pkg::LOAD) && wr_open && i_wr_valid && mem_req.accept;
    assign o_load_complete = (phase == stream_pkg::SERVE);

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            phase     <= stream_pkg::LOAD;
            wr_addr   <= '0;
            wr_open   <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            if (wr_take) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (phase == stream_pkg::LOAD) begin
                if (wr_take && i_wr_last) begin
                    wr_open   <= 1'b0;
                    last_seen <= 1'b1;
                end else if (!last_seen) begin
                    wr_open <= 1'b1;
                end
                // load is done once memory has acked every write
                if (last_seen && mem_req.writes_idle) begin
                    phase <= stream_pkg::SERVE;
                end
            end
        end
    end

    assert property (@(posedge i_clk_dram_ctrl) disable iff (i_rst)
        (phase == stream_pkg::LOAD && last_seen) |-> !mem_req.valid);

endmodule

// File: logic/memrequest_port.sv
module memrequest_port (
    input  logic                    i_clk_dram_ctrl,
    input  logic                    i_rst,
    mem_req_if.sink                 mem_req,
    read_resp_if.source             rd_resp,
    output logic                    o_mem_en,
    output logic                    o_mem_we,
    output dram_pkg::mem_addr_t     o_mem_addr,
    output dram_pkg::mem_data_t     o_mem_wdata,
    input  logic                    i_mem_busy,
    input  logic                    i_mem_complete,
    input  dram_pkg::mem_data_t     i_mem_rdata,
    output dram_pkg::event_count_t  o_mem_complete_count
);

    // in-order record of requests in flight
    logic                q_is_rd [dram_pkg::MEM_OUTSTANDING];
    dram_pkg::mem_addr_t q_addr  [dram_pkg::MEM_OUTSTANDING];
    logic                q_last  [dram_pkg::MEM_OUTSTANDING];

    dram_pkg::mem_ptr_t     q_wr_ptr;
    dram_pkg::mem_ptr_t     q_rd_ptr;
    dram_pkg::mem_count_t   q_count;
    dram_pkg::mem_count_t   rd_out;     // reads in flight
    dram_pkg::mem_count_t   wr_out;     // writes in flight
    dram_pkg::event_count_t complete_count;

    logic room;
    logic credit_ok;
    logic push;
    logic pop;
    logic push_rd;
    logic pop_rd;

    assign room      = q_count < dram_pkg::MEM_OUTSTANDING;
    assign credit_ok = mem_req.we || (rd_out < rd_resp.free_slots);  // read needs a buffer slot

    // request is held on the port while busy, room and credit only grow meanwhile
    assign o_mem_en       = mem_req.valid && room && credit_ok;
    assign o_mem_we       = mem_req.we;
    assign o_mem_addr     = mem_req.addr;
    assign o_mem_wdata    = mem_req.wdata;
    assign mem_req.accept = !i_mem_busy && room && credit_ok;

    assign push    = mem_req.valid && mem_req.accept;
    assign pop     = i_mem_complete;
    assign push_rd = push && !mem_req.we;
    assign pop_rd  = pop && q_is_rd[q_rd_ptr];

    assign mem_req.writes_idle = (wr_out == '0);

    // completion of the head read goes straight out
    assign rd_resp.valid = pop_rd;
    assign rd_resp.addr  = q_addr[q_rd_ptr];
    assign rd_resp.last  = q_last[q_rd_ptr];
    assign rd_resp.data  = i_mem_rdata;

    assign o_mem_complete_count = complete_count;

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (push) begin
            q_is_rd[q_wr_ptr] <= !mem_req.we;
            q_addr[q_wr_ptr]  <= mem_req.addr;
            q_last[q_wr_ptr]  <= mem_req.rd_tag_last;
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            q_wr_ptr       <= '0;
            q_rd_ptr       <= '0;
            q_count        <= '0;
            rd_out         <= '0;
            wr_out         <= '0;
            complete_count <= '0;
        end else begin
            if (push) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (pop) begin
                q_rd_ptr       <= q_rd_ptr + 1'b1;
                complete_count <= complete_count + 1'b1;
            end
            q_count <= q_count + dram_pkg::mem_count_t'(push) - dram_pkg::mem_count_t'(pop);
            rd_out  <= rd_out + dram_pkg::mem_count_t'(push_rd) - dram_pkg::mem_count_t'(pop_rd);
            wr_out  <= wr_out + dram_pkg::mem_count_t'(push && mem_req.we)
                       - dram_pkg::mem_count_t'(pop && !q_is_rd[q_rd_ptr]);
        end
    end

    assert property (@(posedge i_clk_dram_ctrl) disable iff (i_rst)
        i_mem_complete |-> q_count != '0);

    // split counts must add up to the queue fill
    assert property (@(posedge i_clk_dram_ctrl) disable iff (i_rst)
        (q_count <= dram_pkg::MEM_OUTSTANDING) && ((rd_out + wr_out) == q_count));

endmodule

// File: logic/read_response_queue.sv
module read_response_queue (
    input  logic                   i_clk_dram_ctrl,
    input  logic                   i_rst,
    read_resp_if.sink              rd_resp,
    output dram_pkg::mem_data_t    o_rd_data,
    output dram_pkg::mem_addr_t    o_rd_resp_addr,
    output logic                   o_rd_resp_last,
    output logic                   o_rd_valid,
    input  logic                   i_rd_ready,
    output dram_pkg::event_count_t o_rd_delivered_count
);

    dram_pkg::mem_addr_t buf_addr [stream_pkg::RESP_DEPTH];
    logic                buf_last [stream_pkg::RESP_DEPTH];
    dram_pkg::mem_data_t buf_data [stream_pkg::RESP_DEPTH];

    stream_pkg::resp_ptr_t   wr_ptr;
    stream_pkg::resp_ptr_t   rd_ptr;
    stream_pkg::resp_slots_t count;
    dram_pkg::event_count_t  delivered;
    logic                    take;

    assign take = o_rd_valid && i_rd_ready;

    assign o_rd_valid     = (count != '0);
    assign o_rd_data      = buf_data[rd_ptr];
    assign o_rd_resp_addr = buf_addr[rd_ptr];
    assign o_rd_resp_last = buf_last[rd_ptr];

    assign rd_resp.free_slots   = stream_pkg::resp_slots_t'(stream_pkg::RESP_DEPTH) - count;
    assign o_rd_delivered_count = delivered;

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (rd_resp.valid) begin
            buf_addr[wr_ptr] <= rd_resp.addr;
            buf_last[wr_ptr] <= rd_resp.last;
            buf_data[wr_ptr] <= rd_resp.data;
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            delivered <= '0;
        end else begin
            if (rd_resp.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr    <= rd_ptr + 1'b1;
                delivered <= delivered + 1'b1;
            end
            count <= count + stream_pkg::resp_slots_t'(rd_resp.valid)
                     - stream_pkg::resp_slots_t'(take);
        end
    end

    // credit at the port must keep the buffer from overflowing
    assert property (@(posedge i_clk_dram_ctrl) disable iff (i_rst)
        rd_resp.valid |-> rd_resp.free_slots != '0);

    assert property (@(posedge i_clk_dram_ctrl) disable iff (i_rst)
        (o_rd_valid && !i_rd_ready) |=> o_rd_valid && $stable(o_rd_data)
            && $stable(o_rd_resp_addr) && $stable(o_rd_resp_last));

endmodule

// File: logic/sample_memory_subsystem.sv
module sample_memory_subsystem (
    input  logic                   i_clk_dram_ctrl,
    input  logic                   i_rst,
    // write stream, sample chunks
    input  dram_pkg::mem_data_t    i_wr_data,
    input  logic                   i_wr_last,
    input  logic                   i_wr_valid,
    output logic                   o_wr_ready,
    // read-address stream
    input  dram_pkg::mem_addr_t    i_rd_addr,
    input  logic                   i_rd_last,
    input  logic                   i_rd_valid,
    output logic                   o_rd_addr_ready,
    // read-data stream
    output dram_pkg::mem_data_t    o_rd_data,
    output dram_pkg::mem_addr_t    o_rd_resp_addr,
    output logic                   o_rd_resp_last,
    output logic                   o_rd_valid,
    input  logic                   i_rd_ready,
    // memory request port
    output logic                   o_mem_en,
    output logic                   o_mem_we,
    output dram_pkg::mem_addr_t    o_mem_addr,
    output dram_pkg::mem_data_t    o_mem_wdata,
    input  logic                   i_mem_busy,
    input  logic                   i_mem_complete,
    input  dram_pkg::mem_data_t    i_mem_rdata,
    // status for the display
    output logic                   o_load_complete,
    output dram_pkg::event_count_t o_mem_complete_count,
    output dram_pkg::event_count_t o_rd_delivered_count
);

    mem_req_if   mem_req ();
    read_resp_if rd_resp ();

    traffic_generator traffic_generator_inst (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_rst           (i_rst),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .i_wr_valid      (i_wr_valid),
        .o_wr_ready      (o_wr_ready),
        .i_rd_addr       (i_rd_addr),
        .i_rd_last       (i_rd_last),
        .i_rd_valid      (i_rd_valid),
        .o_rd_addr_ready (o_rd_addr_ready),
        .o_load_complete (o_load_complete),
        .mem_req         (mem_req.source)
    );

    memrequest_port memrequest_port_inst (
        .i_clk_dram_ctrl      (i_clk_dram_ctrl),
        .i_rst                (i_rst),
        .mem_req              (mem_req.sink),
        .rd_resp              (rd_resp.source),
        .o_mem_en             (o_mem_en),
        .o_mem_we             (o_mem_we),
        .o_mem_addr           (o_mem_addr),
        .o_mem_wdata          (o_mem_wdata),
        .i_mem_busy           (i_mem_busy),
        .i_mem_complete       (i_mem_complete),
        .i_mem_rdata          (i_mem_rdata),
        .o_mem_complete_count (o_mem_complete_count)
    );

    read_response_queue read_response_queue_inst (
        .i_clk_dram_ctrl      (i_clk_dram_ctrl),
        .i_rst                (i_rst),
        .rd_resp              (rd_resp.sink),
        .o_rd_data            (o_rd_data),
        .o_rd_resp_addr       (o_rd_resp_addr),
        .o_rd_resp_last       (o_rd_resp_last),
        .o_rd_valid           (o_rd_valid),
        .i_rd_ready           (i_rd_ready),
        .o_rd_delivered_count (o_rd_delivered_count)
    );

endmodule

// File: verif/tb_sample_memory_subsystem.sv
module tb_sample_memory_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk_dram_ctrl;
    logic                   rst;
    dram_pkg::mem_data_t    i_wr_data;
    logic                   i_wr_last, i_wr_valid, o_wr_ready;
    dram_pkg::mem_addr_t    i_rd_addr;
    logic                   i_rd_last, i_rd_valid, o_rd_addr_ready;
    dram_pkg::mem_data_t    o_rd_data;
    dram_pkg::mem_addr_t    o_rd_resp_addr;
    logic                   o_rd_resp_last, o_rd_valid, i_rd_ready;
    logic                   o_mem_en, o_mem_we, i_mem_busy, i_mem_complete;
    dram_pkg::mem_addr_t    o_mem_addr;
    dram_pkg::mem_data_t    o_mem_wdata, i_mem_rdata;
    logic                   o_load_complete;
    dram_pkg::event_count_t o_mem_complete_count, o_rd_delivered_count;

    // test lines in file order
    byte                 op_kind [$];
    dram_pkg::mem_data_t op_data [$];
    dram_pkg::mem_addr_t op_addr [$];
    logic                op_last [$];
    int                  op_len  [$];

    dram_pkg::mem_data_t ref_data [$];   // write n lands at address n
    dram_pkg::mem_addr_t exp_addr [$];
    logic                exp_last [$];

    // memory model state
    dram_pkg::mem_data_t mem_store [dram_pkg::mem_addr_t];
    logic                pend_is_rd [$];
    dram_pkg::mem_addr_t pend_addr  [$];
    int                  pend_due   [$];
    logic                cpl_is_wr = 1'b0;

    integer seed = 32'h60d09ec7;
    int     cycle = 0;
    int     cycle_limit = 0;
    int     wr_accepted = 0;
    int     wr_completed = 0;
    int     rd_seen = 0;
    int     n_rd = 0;
    int     stall_left = 0;
    int     mismatches = 0;
    int     other_errors = 0;
    logic   last_wr_done = 1'b0;
    logic   load_seen = 1'b0;

    sample_memory_subsystem sample_memory_subsystem_inst (
        .i_clk_dram_ctrl      (clk_dram_ctrl),
        .i_rst                (rst),
        .i_wr_data            (i_wr_data),
        .i_wr_last            (i_wr_last),
        .i_wr_valid           (i_wr_valid),
        .o_wr_ready           (o_wr_ready),
        .i_rd_addr            (i_rd_addr),
        .i_rd_last            (i_rd_last),
        .i_rd_valid           (i_rd_valid),
        .o_rd_addr_ready      (o_rd_addr_ready),
        .o_rd_data            (o_rd_data),
        .o_rd_resp_addr       (o_rd_resp_addr),
        .o_rd_resp_last       (o_rd_resp_last),
        .o_rd_valid           (o_rd_valid),
        .i_rd_ready           (i_rd_ready),
        .o_mem_en             (o_mem_en),
        .o_mem_we             (o_mem_we),
        .o_mem_addr           (o_mem_addr),
        .o_mem_wdata          (o_mem_wdata),
        .i_mem_busy           (i_mem_busy),
        .i_mem_complete       (i_mem_complete),
        .i_mem_rdata          (i_mem_rdata),
        .o_load_complete      (o_load_complete),
        .o_mem_complete_count (o_mem_complete_count),
        .o_rd_delivered_count (o_rd_delivered_count)
    );

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #5 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    task automatic check_data(input string name, input dram_pkg::mem_data_t got,
                              input dram_pkg::mem_data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dram_pkg::mem_addr_t got,
                              input dram_pkg::mem_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input dram_pkg::event_count_t got,
                               input dram_pkg::event_count_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic read_tests();
        int                  fd;
        int                  code;
        string               tok;
        string               rest;
        dram_pkg::mem_data_t d;
        dram_pkg::mem_addr_t a;
        logic                l;
        int                  n;
        fd = $fopen("verif/sample_memory_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open verif/sample_memory_tests.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                d = '0;
                a = '0;
                l = 1'b0;
                n = 0;
                if (tok.getc(0) == "#") begin
                    code = $fgets(rest, fd);   // comment line
                end else if (tok == "W") begin
                    code = $fscanf(fd, "%h %b", d, l);
                    ref_data.push_back(d);
                end else if (tok == "R") begin
                    code = $fscanf(fd, "%h %b", a, l);
                    exp_addr.push_back(a);
                    exp_last.push_back(l);
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%d", n);
                end else begin
                    other_errors++;
                    $display("unknown line kind %s in the test file", tok);
                    code = $fgets(rest, fd);
                end
                if (tok == "W" || tok == "R" || tok == "P") begin
                    op_kind.push_back(tok.getc(0));
                    op_data.push_back(d);
                    op_addr.push_back(a);
                    op_last.push_back(l);
                    op_len.push_back(n);
                end
            end
            $fclose(fd);
        end
        n_rd = exp_addr.size();
    endtask

    task automatic send_write(input dram_pkg::mem_data_t data, input logic last);
        @(negedge clk_dram_ctrl);
        i_rd_valid = 1'b0;
        i_wr_data  = data;
        i_wr_last  = last;
        i_wr_valid = 1'b1;
        @(posedge clk_dram_ctrl);
        while (!o_wr_ready) @(posedge clk_dram_ctrl);
    endtask

    task automatic send_read(input dram_pkg::mem_addr_t addr, input logic last);
        @(negedge clk_dram_ctrl);
        i_wr_valid = 1'b0;
        i_rd_addr  = addr;
        i_rd_last  = last;
        i_rd_valid = 1'b1;
        @(posedge clk_dram_ctrl);
        while (!o_rd_addr_ready) @(posedge clk_dram_ctrl);   // held until SERVE
    endtask

    // memory model drive side plus output back-pressure
    always @(negedge clk_dram_ctrl) begin
        i_mem_complete = 1'b0;
        i_mem_busy     = (($random(seed) & 3) == 0) && !rst;
        if (!rst && pend_due.size() > 0 && pend_due[0] == cycle + 1) begin
            i_mem_complete = 1'b1;
            cpl_is_wr      = !pend_is_rd[0];
            i_mem_rdata    = '0;
            if (pend_is_rd[0] && mem_store.exists(pend_addr[0])) begin
                i_mem_rdata = mem_store[pend_addr[0]];
            end
            void'(pend_is_rd.pop_front());
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        if (stall_left > 0) begin
            i_rd_ready = 1'b0;
            stall_left--;
        end else begin
            i_rd_ready = !rst;
        end
    end

    // accept side of the memory model and the output monitor
    always @(posedge clk_dram_ctrl) begin
        if (!rst) begin
            cycle++;
            if (o_mem_en && !i_mem_busy) begin
                // a request completing this cycle still counts as in flight
                if (pend_due.size() + int'(i_mem_complete) >= dram_pkg::MEM_OUTSTANDING) begin
                    other_errors++;
                    $display("memory accepted a request with %0d already in flight",
                             pend_due.size() + int'(i_mem_complete));
                end
                if (o_mem_we) begin
                    if (wr_accepted >= ref_data.size()) begin
                        other_errors++;
                        $display("write request after the end of the write stream");
                    end else begin
                        check_addr("o_mem_addr", o_mem_addr,
                                   dram_pkg::mem_addr_t'(wr_accepted));
                        check_data("o_mem_wdata", o_mem_wdata, ref_data[wr_accepted]);
                    end
                    mem_store[o_mem_addr] = o_mem_wdata;
                    wr_accepted++;
                end
                pend_is_rd.push_back(!o_mem_we);
                pend_addr.push_back(o_mem_addr);
                pend_due.push_back(cycle + 4);   // pulse starts 3 cycles after the accept edge
            end
            if (!last_wr_done) begin
                check_bit("o_load_complete", o_load_complete, 1'b0);
                check_bit("o_rd_addr_ready", o_rd_addr_ready, 1'b0);
            end
            if (load_seen) begin
                check_bit("o_load_complete", o_load_complete, 1'b1);
                check_bit("o_wr_ready", o_wr_ready, 1'b0);
            end
            if (o_load_complete) load_seen = 1'b1;
            if (i_mem_complete && cpl_is_wr) begin
                wr_completed++;
                if (wr_completed == ref_data.size()) last_wr_done = 1'b1;
            end
            if (o_rd_valid && i_rd_ready) begin
                if (exp_addr.size() == 0) begin
                    other_errors++;
                    $display("read beat delivered with no read request left to match");
                end else begin
                    check_addr("o_rd_resp_addr", o_rd_resp_addr, exp_addr[0]);
                    check_bit("o_rd_resp_last", o_rd_resp_last, exp_last[0]);
                    if (int'(exp_addr[0]) < ref_data.size()) begin
                        check_data("o_rd_data", o_rd_data, ref_data[exp_addr[0]]);
                    end else begin
                        other_errors++;
                        $display("test file reads an address that was never written");
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_last.pop_front());
                end
                rd_seen++;
            end
        end
    end

    initial begin
        int waited;
        waited = 0;
        wait (cycle_limit > 0);
        while (waited < cycle_limit) begin
            @(posedge clk_dram_ctrl);
            waited++;
        end
        $display("timeout, run did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        i_wr_data      = '0;
        i_wr_last      = 1'b0;
        i_wr_valid     = 1'b0;
        i_rd_addr      = '0;
        i_rd_last      = 1'b0;
        i_rd_valid     = 1'b0;
        i_rd_ready     = 1'b0;
        i_mem_busy     = 1'b0;
        i_mem_complete = 1'b0;
        i_mem_rdata    = '0;
        read_tests();
        cycle_limit = 40 * op_kind.size() + 200;
        repeat (10) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        check_bit("o_wr_ready", o_wr_ready, 1'b0);       // reset values
        check_bit("o_rd_addr_ready", o_rd_addr_ready, 1'b0);
        check_bit("o_mem_en", o_mem_en, 1'b0);
        check_bit("o_rd_valid", o_rd_valid, 1'b0);
        check_bit("o_load_complete", o_load_complete, 1'b0);
        check_count("o_mem_complete_count", o_mem_complete_count, '0);
        check_count("o_rd_delivered_count", o_rd_delivered_count, '0);
        rst = 1'b0;
        foreach (op_kind[i]) begin
            if (op_kind[i] == "W") begin
                send_write(op_data[i], op_last[i]);
            end else if (op_kind[i] == "R") begin
                send_read(op_addr[i], op_last[i]);
            end else begin
                @(posedge clk_dram_ctrl);
                stall_left = op_len[i];   // output stalls, reads keep coming
            end
        end
        @(negedge clk_dram_ctrl);
        i_wr_valid = 1'b0;
        i_rd_valid = 1'b0;
        while (rd_seen < n_rd) @(negedge clk_dram_ctrl);
        check_count("o_mem_complete_count", o_mem_complete_count,
                    dram_pkg::event_count_t'(ref_data.size() + n_rd));
        check_count("o_rd_delivered_count", o_rd_delivered_count,
                    dram_pkg::event_count_t'(n_rd));
        if (wr_completed != ref_data.size()) begin
            other_errors++;
            $display("only %0d of %0d writes completed", wr_completed, ref_data.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/sample_memory_tests.txt
# W <128-bit data hex> <last> | R <burst address hex> <last>
# P <cycles of output back-pressure, starting at that point>
W 00010002000300040005000600070008 0
W 7fff8000123fedc1a5a55a5a0f0ff0f0 0
W fffe0001fffd0002fffc0003fffb0004 0
W 0badc0de0badc0de0badc0de0badc0de 0
W 123456789abcdef0fedcba9876543210 0
W 80007fff80007fff80007fff80007fff 0
W 00000000000000000000000000000000 0
W c3c3c3c33c3c3c3ca5a5a5a55a5a5a5a 1
R 000000 0
R 000001 0
R 000002 0
R 000003 1
P 12
R 000004 0
R 000005 0
R 000006 0
R 000007 1
R 000002 0
P 9
R 000000 0
R 000007 0
R 000004 1

// File: sample_memory_subsystem.f
logic/dram_pkg.sv
logic/stream_pkg.sv
logic/dram_link_ifs.sv
logic/traffic_generator.sv
logic/memrequest_port.sv
logic/read_response_queue.sv
logic/sample_memory_subsystem.sv
verif/tb_sample_memory_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sample_memory_subsystem
FILELIST  ?= sample_memory_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv) $(wildcard verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
